// File: Makefile
VERILATOR ?= verilator
TOP       ?= tcad_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
+incdir+include
logic/tcad_mem_pkg.sv
logic/tcad_pe_pkg.sv
logic/lsu_if.sv
logic/spm_banks.sv
logic/lsu_crossbar.sv
logic/pe_lane.sv
logic/pe_array.sv
logic/tcad.sv
verification/tcad_tb.sv

// File: include/tcad_config.svh
`ifndef TCAD_CONFIG_SVH
`define TCAD_CONFIG_SVH

// Processing-element lanes, each one load/store port into the crossbar
`define TCAD_LANES 4

// Scratchpad banks, word-interleaved on the low address bits
`define TCAD_BANKS 4

`define TCAD_WORD_W 32
`define TCAD_ADDR_W 8

`endif

// File: logic/lsu_crossbar.sv
`timescale 1ns/1ns
`include "tcad_config.svh"

module lsu_crossbar import tcad_mem_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    lsu_if.crossbar                lsu [`TCAD_LANES],
    output logic [`TCAD_BANKS-1:0] bank_en,
    output logic [`TCAD_BANKS-1:0] bank_we,
    output row_t                   bank_row   [`TCAD_BANKS],
    output word_t                  bank_wdata [`TCAD_BANKS],
    input  word_t                  bank_rdata [`TCAD_BANKS]
);

    logic [`TCAD_LANES-1:0] req_v;
    logic [`TCAD_LANES-1:0] we_v;
    logic [`TCAD_LANES-1:0] grant_v;
    logic [`TCAD_LANES-1:0] rvalid_v;
    bank_t                  bank_v   [`TCAD_LANES];
    row_t                   row_v    [`TCAD_LANES];
    word_t                  wdata_v  [`TCAD_LANES];
    word_t                  rdata_v  [`TCAD_LANES];
    lane_id_t               win_lane [`TCAD_BANKS];
    logic [`TCAD_BANKS-1:0] rd_pend;
    lane_id_t               rd_lane  [`TCAD_BANKS];

    // Flatten the interface array so the arbiter can loop over lanes
    for (genvar l = 0; l < `TCAD_LANES; l++) begin : g_lane
        assign req_v[l]      = lsu[l].req;
        assign we_v[l]       = lsu[l].we;
        assign bank_v[l]     = bank_t'(lsu[l].addr);
        assign row_v[l]      = row_t'(lsu[l].addr >> BANK_W);
        assign wdata_v[l]    = lsu[l].wdata;
        assign lsu[l].grant  = grant_v[l];
        assign lsu[l].rvalid = rvalid_v[l];
        assign lsu[l].rdata  = rdata_v[l];
    end

    always_comb begin
        grant_v = '0;
        bank_en = '0;
        bank_we = '0;
        for (int b = 0; b < `TCAD_BANKS; b++) begin
            win_lane[b] = '0;
            // Scan downwards so the lowest requesting lane is left as winner
            for (int l = `TCAD_LANES - 1; l >= 0; l--) begin
                if (req_v[l] && (bank_v[l] == bank_t'(b))) begin
                    bank_en[b]  = 1'b1;
                    win_lane[b] = lane_id_t'(l);
                end
            end
            bank_we[b]    = bank_en[b] && we_v[win_lane[b]];
            bank_row[b]   = row_v[win_lane[b]];
            bank_wdata[b] = wdata_v[win_lane[b]];
            if (bank_en[b]) begin
                grant_v[win_lane[b]] = 1'b1;  // A lane targets one bank only
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_pend <= '0;
            for (int b = 0; b < `TCAD_BANKS; b++) begin
                rd_lane[b] <= '0;
            end
        end else begin
            rd_pend <= bank_en & ~bank_we;
            for (int b = 0; b < `TCAD_BANKS; b++) begin
                rd_lane[b] <= win_lane[b];
            end
        end
    end

    always_comb begin
        rvalid_v = '0;
        for (int l = 0; l < `TCAD_LANES; l++) begin
            rdata_v[l] = '0;
        end
        for (int b = 0; b < `TCAD_BANKS; b++) begin
            if (rd_pend[b]) begin
                rvalid_v[rd_lane[b]] = 1'b1;
                rdata_v[rd_lane[b]]  = bank_rdata[b];
            end
        end
    end

endmodule

// File: logic/lsu_if.sv
`timescale 1ns/1ns

interface lsu_if import tcad_mem_pkg::*; ();

    logic  req;     // Held by the lane until grant
    logic  we;
    addr_t addr;
    word_t wdata;
    logic  grant;   // Same cycle as the winning request
    logic  rvalid;  // One clock after a granted read
    word_t rdata;

    modport lane (
        output req,
        output we,
        output addr,
        output wdata,
        input  grant,
        input  rvalid,
        input  rdata
    );

    modport crossbar (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output grant,
        output rvalid,
        output rdata
    );

endinterface

// File: logic/pe_array.sv
`timescale 1ns/1ns
`include "tcad_config.svh"

module pe_array import tcad_mem_pkg::*, tcad_pe_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     cfg_valid,
    input  lane_id_t cfg_lane,
    input  addr_t    cfg_src,
    input  word_t    cfg_data,
    input  logic     start,
    output logic     busy,
    output word_t    result,
    output logic     done,
    lsu_if.lane      lsu [`TCAD_LANES]
);

    addr_t                  src_r    [`TCAD_LANES];
    addr_t                  dst_r    [`TCAD_LANES];
    count_t                 cnt_r    [`TCAD_LANES];
    konst_t                 konst_r  [`TCAD_LANES];
    word_t                  lane_sum [`TCAD_LANES];
    logic [`TCAD_LANES-1:0] lane_idle;
    word_t                  total;
    logic                   running;

    // A lane never configured keeps count zero and sits out every run
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int l = 0; l < `TCAD_LANES; l++) begin
                cnt_r[l] <= '0;
            end
        end else if (cfg_valid) begin
            cnt_r[cfg_lane] <= count_t'(cfg_data[23:16]);
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_valid) begin
            src_r[cfg_lane]   <= cfg_src;
            dst_r[cfg_lane]   <= addr_t'(cfg_data[31:24]);
            konst_r[cfg_lane] <= konst_t'(cfg_data[15:0]);
        end
    end

    for (genvar l = 0; l < `TCAD_LANES; l++) begin : g_lane
        pe_lane u_lane (
            .clk    (clk),
            .arst_n (arst_n),
            .start  (start),
            .src    (src_r[l]),
            .dst    (dst_r[l]),
            .count  (cnt_r[l]),
            .konst  (konst_r[l]),
            .idle   (lane_idle[l]),
            .sum    (lane_sum[l]),
            .lsu    (lsu[l])
        );
    end

    always_comb begin
        total = '0;
        for (int l = 0; l < `TCAD_LANES; l++) begin
            total = total + lane_sum[l];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
            done    <= 1'b0;
            result  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
            end else if (running && (&lane_idle)) begin
                running <= 1'b0;  // Lanes left IDLE one cycle after start
                done    <= 1'b1;
                result  <= total;
            end
        end
    end

    assign busy = running;

endmodule

// File: logic/pe_lane.sv
`timescale 1ns/1ns

module pe_lane import tcad_mem_pkg::*, tcad_pe_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   start,
    input  addr_t  src,
    input  addr_t  dst,
    input  count_t count,
    input  konst_t konst,
    output logic   idle,
    output word_t  sum,
    lsu_if.lane    lsu
);

    lane_state_t state;
    count_t      idx;
    word_t       val;
    logic        last;

    assign last = (idx + count_t'(1)) == count;
    assign idle = (state == IDLE);

    // Request stays up in READ and WRITE until the crossbar grants it
    assign lsu.req   = (state == READ) || (state == WRITE);
    assign lsu.we    = (state == WRITE);
    assign lsu.addr  = ((state == WRITE) ? dst : src) + addr_t'(idx);
    assign lsu.wdata = val;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            idx   <= '0;
            sum   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        sum <= '0;
                        idx <= '0;
                        if (count != '0) begin
                            state <= READ;
                        end
                    end
                end
                READ: begin
                    if (lsu.grant) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (lsu.rvalid) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    if (lsu.grant) begin
                        sum   <= sum + val;  // Wraps modulo 2^32
                        idx   <= idx + count_t'(1);
                        state <= last ? IDLE : READ;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == WAIT) && lsu.rvalid) begin
            val <= lsu.rdata + word_t'(konst);
        end
    end

endmodule

// File: logic/spm_banks.sv
`timescale 1ns/1ns
`include "tcad_config.svh"

module spm_banks import tcad_mem_pkg::*; (
    input  logic                   clk,
    input  logic                   host_en,
    input  logic                   host_we,
    input  addr_t                  host_addr,
    input  word_t                  host_wdata,
    output word_t                  host_rdata,
    input  logic [`TCAD_BANKS-1:0] bank_en,
    input  logic [`TCAD_BANKS-1:0] bank_we,
    input  row_t                   bank_row   [`TCAD_BANKS],
    input  word_t                  bank_wdata [`TCAD_BANKS],
    output word_t                  bank_rdata [`TCAD_BANKS]
);

    localparam int ROWS = 1 << $bits(row_t);

    bank_t host_bank;
    row_t  host_row;
    bank_t host_bank_q;

    assign host_bank = bank_t'(host_addr);
    assign host_row  = row_t'(host_addr >> BANK_W);

    for (genvar b = 0; b < `TCAD_BANKS; b++) begin : g_bank
        word_t mem [ROWS];
        word_t rdata_q;
        logic  hit;
        logic  en;
        logic  we;
        row_t  row;
        word_t wdata;

        // Host wins the port whenever it addresses this bank
        assign hit   = host_en && (host_bank == bank_t'(b));
        assign en    = hit || bank_en[b];
        assign we    = hit ? host_we : bank_we[b];
        assign row   = hit ? host_row : bank_row[b];
        assign wdata = hit ? host_wdata : bank_wdata[b];

        always_ff @(posedge clk) begin
            if (en) begin
                if (we) begin
                    mem[row] <= wdata;
                end else begin
                    rdata_q <= mem[row];  // Read word is ready the next cycle
                end
            end
        end

        assign bank_rdata[b] = rdata_q;
    end

    always_ff @(posedge clk) begin
        if (host_en) begin
            host_bank_q <= host_bank;  // Steers the host read word next cycle
        end
    end

    assign host_rdata = bank_rdata[host_bank_q];

endmodule

// File: logic/tcad.sv
`timescale 1ns/1ns
`include "tcad_config.svh"

module tcad import tcad_mem_pkg::*, tcad_pe_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     cmd_valid,
    input  cmd_op_t  cmd_op,
    input  lane_id_t cmd_lane,
    input  addr_t    cmd_addr,
    input  word_t    cmd_data,
    output logic     rd_valid,
    output word_t    rd_data,
    output word_t    result,
    output logic     done
);

    logic                   cmd_ok;
    logic                   host_en;
    logic                   host_we;
    logic                   cfg_valid;
    logic                   run_start;
    logic                   busy;
    logic [`TCAD_BANKS-1:0] bank_en;
    logic [`TCAD_BANKS-1:0] bank_we;
    row_t                   bank_row   [`TCAD_BANKS];
    word_t                  bank_wdata [`TCAD_BANKS];
    word_t                  bank_rdata [`TCAD_BANKS];

    lsu_if lsu [`TCAD_LANES] ();

    // Host commands are dropped while the lanes own the scratchpad
    assign cmd_ok    = cmd_valid && !busy;
    assign host_en   = cmd_ok && ((cmd_op == SPM_WRITE) || (cmd_op == SPM_READ));
    assign host_we   = (cmd_op == SPM_WRITE);
    assign cfg_valid = cmd_ok && (cmd_op == PE_CONFIG);
    assign run_start = cmd_ok && (cmd_op == RUN);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= cmd_ok && (cmd_op == SPM_READ);
        end
    end

    pe_array u_pe_array (
        .clk       (clk),
        .arst_n    (arst_n),
        .cfg_valid (cfg_valid),
        .cfg_lane  (cmd_lane),
        .cfg_src   (cmd_addr),
        .cfg_data  (cmd_data),
        .start     (run_start),
        .busy      (busy),
        .result    (result),
        .done      (done),
        .lsu       (lsu)
    );

    lsu_crossbar u_crossbar (
        .clk        (clk),
        .arst_n     (arst_n),
        .lsu        (lsu),
        .bank_en    (bank_en),
        .bank_we    (bank_we),
        .bank_row   (bank_row),
        .bank_wdata (bank_wdata),
        .bank_rdata (bank_rdata)
    );

    spm_banks u_spm (
        .clk        (clk),
        .host_en    (host_en),
        .host_we    (host_we),
        .host_addr  (cmd_addr),
        .host_wdata (cmd_data),
        .host_rdata (rd_data),
        .bank_en    (bank_en),
        .bank_we    (bank_we),
        .bank_row   (bank_row),
        .bank_wdata (bank_wdata),
        .bank_rdata (bank_rdata)
    );

endmodule

// File: logic/tcad_mem_pkg.sv
`include "tcad_config.svh"

package tcad_mem_pkg;

    localparam int BANK_W = $clog2(`TCAD_BANKS);
    localparam int LANE_W = $clog2(`TCAD_LANES);

    typedef logic [`TCAD_WORD_W-1:0] word_t;

    // Low BANK_W bits pick the bank and the upper bits pick the row
    typedef logic [`TCAD_ADDR_W-1:0] addr_t;

    typedef logic [BANK_W-1:0] bank_t;
    typedef logic [`TCAD_ADDR_W-BANK_W-1:0] row_t;
    typedef logic [LANE_W-1:0] lane_id_t;

endpackage

// File: logic/tcad_pe_pkg.sv
package tcad_pe_pkg;

    // Host command opcodes carried on cmd_op
    typedef enum logic [1:0] {
        SPM_WRITE = 2'd0,
        SPM_READ  = 2'd1,
        PE_CONFIG = 2'd2,
        RUN       = 2'd3
    } cmd_op_t;

    typedef logic [7:0]  count_t;  // Elements per lane and run
    typedef logic [15:0] konst_t;  // Unsigned addend, zero extended

    // Per-element sequence of one lane
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        READ  = 2'd1,
        WAIT  = 2'd2,
        WRITE = 2'd3
    } lane_state_t;

endpackage

// File: verification/tcad_tb.sv
`timescale 1ns/1ns
`include "tcad_config.svh"

module tcad_tb import tcad_mem_pkg::*, tcad_pe_pkg::*; ();

    localparam int CLK_NS       = 4;
    localparam int RESET_CYCLES = 5;
    localparam int N_SINGLE     = 16;
    localparam int N_CONFLICT   = 12;
    localparam int N_MIXED      = 10;
    localparam int N_LATE       = 20;
    localparam int TOTAL_ELEMS  = N_SINGLE + 4 * N_CONFLICT + 2 * N_MIXED + N_LATE;
    // Fill, full readback, block readbacks, configs, reset and idle time
    localparam int HOST_CYCLES  = 2 * 256 + 2 * TOTAL_ELEMS + 200;
    localparam int WATCHDOG_NS  = (TOTAL_ELEMS * 16 + HOST_CYCLES) * CLK_NS;

    logic     clk;
    logic     arst_n;
    logic     cmd_valid;
    cmd_op_t  cmd_op;
    lane_id_t cmd_lane;
    addr_t    cmd_addr;
    word_t    cmd_data;
    logic     rd_valid;
    word_t    rd_data;
    word_t    result;
    logic     done;

    word_t       shadow   [256];  // Expected scratchpad contents
    addr_t       lane_src [`TCAD_LANES];
    addr_t       lane_dst [`TCAD_LANES];
    count_t      lane_cnt [`TCAD_LANES];
    konst_t      lane_k   [`TCAD_LANES];
    word_t       exp_rd   [$];
    word_t       exp_result;
    logic [31:0] rng_state;
    int          cycles;

    tcad DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_lane  (cmd_lane),
        .cmd_addr  (cmd_addr),
        .cmd_data  (cmd_data),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .result    (result),
        .done      (done)
    );

    always #(CLK_NS / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Applies every lane's writes to the shadow and returns the run total
    function automatic word_t run_reference();
        word_t total;
        word_t v;
        addr_t s;
        addr_t d;
        total = '0;
        for (int l = 0; l < `TCAD_LANES; l++) begin
            for (int i = 0; i < int'(lane_cnt[l]); i++) begin
                s = lane_src[l] + addr_t'(i);  // Wraps modulo 256
                d = lane_dst[l] + addr_t'(i);
                v = shadow[s] + word_t'(lane_k[l]);
                shadow[d] = v;
                total = total + v;
            end
        end
        return total;
    endfunction

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic send(input cmd_op_t op, input lane_id_t lane, input addr_t a,
                        input word_t d);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_lane  = lane;
        cmd_addr  = a;
        cmd_data  = d;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic spm_write(input addr_t a, input word_t d);
        shadow[a] = d;
        send(SPM_WRITE, '0, a, d);
    endtask

    task automatic spm_read(input addr_t a);
        exp_rd.push_back(shadow[a]);
        send(SPM_READ, '0, a, '0);
    endtask

    task automatic read_block(input addr_t base, input int n);
        for (int i = 0; i < n; i++) begin
            spm_read(base + addr_t'(i));
        end
    endtask

    task automatic configure(input int lane, input addr_t src, input addr_t dst,
                             input int n, input konst_t k);
        lane_src[lane] = src;
        lane_dst[lane] = dst;
        lane_cnt[lane] = count_t'(n);
        lane_k[lane]   = k;
        send(PE_CONFIG, lane_id_t'(lane), src, {dst, count_t'(n), k});
    endtask

    task automatic start_run();
        exp_result = run_reference();
        send(RUN, '0, '0, '0);
    endtask

    // Counts falling edges from the RUN strobe until done
    task automatic wait_done(output int n);
        int limit;
        limit = 16;
        for (int l = 0; l < `TCAD_LANES; l++) begin
            limit = limit + 16 * int'(lane_cnt[l]);
        end
        n = 1;
        while (!done) begin
            if (n > limit) begin
                $display("done did not arrive within %0d cycles of RUN", limit);
                abort_run();
            end
            @(negedge clk);
            n++;
        end
    endtask

    // Compares read data and run results as they come out of the DUT
    always @(negedge clk) begin
        if (arst_n) begin
            if (rd_valid) begin
                if (exp_rd.size() == 0) begin
                    $display("rd_valid went high with no read outstanding");
                    abort_run();
                end else begin
                    check("rd_data", rd_data, exp_rd.pop_front());
                end
            end
            if (done) begin
                check("result", result, exp_result);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run still going after %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = SPM_WRITE;
        cmd_lane  = '0;
        cmd_addr  = '0;
        cmd_data  = '0;
        rng_state = 32'h1c31a8d1;
        exp_result = '0;
        // Lanes come out of reset with count zero
        for (int l = 0; l < `TCAD_LANES; l++) begin
            lane_cnt[l] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;

        check("result", result, '0);
        repeat (10) begin
            check("done", word_t'(done), '0);
            check("rd_valid", word_t'(rd_valid), '0);
            @(negedge clk);
        end

        for (int a = 0; a < 256; a++) begin
            spm_write(addr_t'(a), next_rand());
        end
        read_block(8'h00, 256);

        configure(0, 8'h00, 8'h80, N_SINGLE, konst_t'(next_rand()));
        start_run();
        wait_done(cycles);
        read_block(8'h80, N_SINGLE);

        // Same bank offsets on every lane, so reads and writes collide
        for (int l = 0; l < `TCAD_LANES; l++) begin
            configure(l, addr_t'(l * 32), addr_t'(8'h90 + l * 16), N_CONFLICT,
                      konst_t'(next_rand()));
        end
        start_run();
        wait_done(cycles);
        for (int l = 0; l < `TCAD_LANES; l++) begin
            read_block(addr_t'(8'h90 + l * 16), N_CONFLICT);
        end

        configure(0, 8'h10, 8'hd0, N_MIXED, konst_t'(next_rand()));
        configure(1, 8'h50, 8'hf0, 0, konst_t'(next_rand()));
        configure(2, 8'h30, 8'he0, N_MIXED, konst_t'(next_rand()));
        configure(3, 8'h70, 8'hf8, 0, konst_t'(next_rand()));
        start_run();
        wait_done(cycles);
        read_block(8'hd0, N_MIXED);
        read_block(8'he0, N_MIXED);
        read_block(8'hf0, 16);

        for (int l = 0; l < `TCAD_LANES; l++) begin
            configure(l, addr_t'(l * 16), addr_t'(8'h80 + l * 16), 0, '0);
        end
        start_run();
        wait_done(cycles);
        if (cycles != 2) begin
            $display("empty run gave done %0d cycles after RUN instead of 2", cycles);
            abort_run();
        end

        configure(0, 8'h00, 8'h40, N_LATE, konst_t'(next_rand()));
        start_run();
        send(SPM_WRITE, '0, 8'hf5, next_rand());  // Shadow keeps the old word
        wait_done(cycles);
        read_block(8'h40, N_LATE);
        spm_read(8'hf5);

        repeat (3) @(negedge clk);
        if (exp_rd.size() != 0) begin
            $display("%0d reads never returned rd_valid", exp_rd.size());
            abort_run();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule
